// ==== spi_pkg.sv ====
`default_nettype none

// types for capturing the spi flash bus and logging what was seen on it
package spi_pkg;

	// one byte as clocked on mosi or miso
	typedef logic [7:0] spi_byte_t;

	// position inside a transaction, 0 is the command byte
	typedef logic [15:0] byte_idx_t;

	// bit position inside the byte being assembled
	typedef logic [2:0] bit_cnt_t;

	// the four bus pins, sampled together
	typedef struct packed {
		logic cs_n;
		logic sclk;
		logic mosi;
		logic miso;
	} spi_pins_t;

	// log record, the top byte goes out on the serial line first
	typedef struct packed {
		byte_idx_t idx;
		spi_byte_t mosi;
		spi_byte_t miso;
	} spi_rec_t;

	// records lost to a full fifo, sticks at all ones
	typedef logic [7:0] drop_count_t;

	// serial bytes needed for one record
	localparam int REC_BYTES = $bits(spi_rec_t) / 8;

endpackage

`default_nettype wire

// ==== uart_pkg.sv ====
`default_nettype none

// 8N1 framing for the log output
package uart_pkg;

	// data bits per frame, lsb first on the line
	localparam int DATA_BITS = 8;
	// start bit, data bits, one stop bit
	localparam int FRAME_BITS = DATA_BITS + 2;

	// line levels
	localparam logic START_BIT = 1'b0;
	localparam logic STOP_BIT = 1'b1;
	localparam logic IDLE_LEVEL = 1'b1;

	typedef logic [DATA_BITS-1:0] uart_byte_t;

	// which bit of the frame is on the line, 0 is the start bit
	typedef logic [$clog2(FRAME_BITS)-1:0] frame_bit_t;

	// data byte plus stop bit, shifted out lsb first after the start bit
	typedef logic [FRAME_BITS-2:0] frame_tail_t;

endpackage

`default_nettype wire

// ==== spi_sniffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_sniffer #(
	parameter int HEADER_BYTES = 3
) (
	input logic clk,
	input logic reset,
	input logic spi_cs_n_i,
	input logic spi_clk_i,
	input logic spi_mosi_i,
	input logic spi_miso_i,
	output logic push_o,
	output spi_pkg::spi_rec_t rec_o
);
	import spi_pkg::*;

	// last index that still gets logged
	localparam byte_idx_t HDR_IDX = byte_idx_t'(HEADER_BYTES);

	spi_pins_t pins_meta;
	spi_pins_t pins_sync;
	logic sclk_prev;
	logic sclk_rise;
	bit_cnt_t bit_cnt;
	spi_byte_t mosi_sr;
	spi_byte_t miso_sr;
	spi_byte_t mosi_byte;
	spi_byte_t miso_byte;
	byte_idx_t idx;

	////////////////////////////////////////
	// pin synchronizers
	////////////////////////////////////////

	// two flops per pin, the bus is driven by someone else
	// cs comes out of reset deasserted so nothing is captured early
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			pins_meta <= '{cs_n: 1'b1, default: 1'b0};
			pins_sync <= '{cs_n: 1'b1, default: 1'b0};
			sclk_prev <= 1'b0;
		end
		else
		begin
			pins_meta <= '{cs_n: spi_cs_n_i, sclk: spi_clk_i,
				mosi: spi_mosi_i, miso: spi_miso_i};
			pins_sync <= pins_meta;
			sclk_prev <= pins_sync.sclk;
		end
	end

	// sample point is the rising edge of the synchronized spi clock
	assign sclk_rise = pins_sync.sclk && !sclk_prev;

	// byte values including the bit arriving now, msb first
	assign mosi_byte = {mosi_sr[6:0], pins_sync.mosi};
	assign miso_byte = {miso_sr[6:0], pins_sync.miso};

	////////////////////////////////////////
	// byte assembly and filter
	////////////////////////////////////////

	// bit counter, transaction index and push strobe
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			bit_cnt <= '0;
			idx <= '0;
			push_o <= 1'b0;
		end
		else
		begin
			push_o <= 1'b0;
			if (pins_sync.cs_n)
			begin
				// deselect drops any partial byte and restarts numbering
				bit_cnt <= '0;
				idx <= '0;
			end
			else if (sclk_rise)
			begin
				// wraps back to 0 after the eighth bit
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == 3'd7)
				begin
					// only the command and the header bytes go to the log
					push_o <= (idx <= HDR_IDX);
					if (idx != '1)
						idx <= idx + 1'b1;
				end
			end
		end
	end

	// shift registers and the outgoing record
	always_ff @(posedge clk)
	begin
		if (sclk_rise && !pins_sync.cs_n)
		begin
			mosi_sr <= mosi_byte;
			miso_sr <= miso_byte;
			if (bit_cnt == 3'd7)
				rec_o <= '{idx: idx, mosi: mosi_byte, miso: miso_byte};
		end
	end

endmodule

`default_nettype wire

// ==== rec_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module rec_fifo #(
	parameter int FIFO_DEPTH = 8
) (
	input logic clk,
	input logic reset,
	input logic push_i,
	input spi_pkg::spi_rec_t rec_i,
	input logic pop_i,
	output logic empty_o,
	output spi_pkg::spi_rec_t rec_o,
	output spi_pkg::drop_count_t dropped_o
);
	import spi_pkg::*;

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	typedef logic [PTR_W-1:0] ptr_t;

	spi_rec_t mem [FIFO_DEPTH];
	ptr_t wr_ptr;
	ptr_t rd_ptr;
	logic [CNT_W-1:0] count;
	logic full;
	logic do_push;
	logic do_pop;

	// step a pointer around the ring, depth need not be a power of two
	function automatic ptr_t ptr_next(input ptr_t ptr);
		if (ptr == ptr_t'(FIFO_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign empty_o = (count == '0);
	assign full = (count == CNT_W'(FIFO_DEPTH));
	// a full fifo turns pushes away, pops on empty are ignored
	assign do_push = push_i && !full;
	assign do_pop = pop_i && !empty_o;

	// head entry is visible without a read cycle
	assign rec_o = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= rec_i;
	end

	// pointers, occupancy and the drop counter
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			dropped_o <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= ptr_next(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_next(rd_ptr);
			// push and pop together leave the count alone
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// lost record, counter sticks at its top value
			if (push_i && full && dropped_o != '1)
				dropped_o <= dropped_o + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== uart_logger.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_logger #(
	parameter int CLKS_PER_BIT = 8
) (
	input logic clk,
	input logic reset,
	input logic empty_i,
	input spi_pkg::spi_rec_t rec_i,
	output logic pop_o,
	output logic txd_o
);
	import spi_pkg::*;
	import uart_pkg::*;

	localparam int BAUD_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
	localparam int BYTE_W = (REC_BYTES > 1) ? $clog2(REC_BYTES) : 1;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_SEND
	} state_t;

	state_t state;
	logic [BAUD_W-1:0] baud_cnt;
	frame_bit_t bit_cnt;
	logic [BYTE_W-1:0] byte_cnt;
	spi_rec_t rec_sr;
	frame_tail_t frame_sr;
	uart_byte_t head_byte;
	logic bit_done;
	logic last_bit;
	logic last_byte;
	logic next_byte;

	// take a record only between records
	assign pop_o = (state == ST_IDLE) && !empty_i;

	// most significant byte of what is left of the record
	assign head_byte = rec_sr[$bits(spi_rec_t)-1 -: DATA_BITS];

	assign bit_done = (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1));
	assign last_bit = (bit_cnt == frame_bit_t'(FRAME_BITS - 1));
	assign last_byte = (byte_cnt == BYTE_W'(REC_BYTES - 1));

	// a new frame starts here, first after the load and then after each stop bit
	assign next_byte = (state == ST_LOAD)
		|| (state == ST_SEND && bit_done && last_bit && !last_byte);

	////////////////////////////////////////
	// record and frame shift registers
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (pop_o)
			rec_sr <= rec_i;
		else if (next_byte)
		begin
			rec_sr <= rec_sr << DATA_BITS;
			frame_sr <= {STOP_BIT, head_byte};
		end
		else if (state == ST_SEND && bit_done && !last_bit)
			frame_sr <= frame_sr >> 1;
	end

	////////////////////////////////////////
	// transmit FSM
	////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= ST_IDLE;
			baud_cnt <= '0;
			bit_cnt <= '0;
			byte_cnt <= '0;
			txd_o <= IDLE_LEVEL;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (pop_o)
						state <= ST_LOAD;
				end
				ST_LOAD:
				begin
					// start bit of the first byte
					txd_o <= START_BIT;
					baud_cnt <= '0;
					bit_cnt <= '0;
					byte_cnt <= '0;
					state <= ST_SEND;
				end
				ST_SEND:
				begin
					if (!bit_done)
						baud_cnt <= baud_cnt + 1'b1;
					else
					begin
						baud_cnt <= '0;
						if (!last_bit)
						begin
							// data bits, then the stop bit
							txd_o <= frame_sr[0];
							bit_cnt <= bit_cnt + 1'b1;
						end
						else if (!last_byte)
						begin
							// next byte follows with no idle gap
							txd_o <= START_BIT;
							bit_cnt <= '0;
							byte_cnt <= byte_cnt + 1'b1;
						end
						else
							// line rests at the stop level
							state <= ST_IDLE;
					end
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== spi_log_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_log_top #(
	parameter int HEADER_BYTES = 3,
	parameter int FIFO_DEPTH = 8,
	parameter int CLKS_PER_BIT = 8
) (
	input logic clk,
	input logic reset,
	input logic spi_cs_n_i,
	input logic spi_clk_i,
	input logic spi_mosi_i,
	input logic spi_miso_i,
	output logic serial_txd_o,
	output spi_pkg::drop_count_t dropped_o
);
	import spi_pkg::*;

	// sniffer to fifo
	logic rec_push;
	spi_rec_t sniff_rec;

	// fifo to logger
	logic fifo_empty;
	logic rec_pop;
	spi_rec_t head_rec;

	////////////////////////////////////////
	// bus capture
	////////////////////////////////////////

	spi_sniffer #(
		.HEADER_BYTES(HEADER_BYTES)
	) u_sniffer (
		.clk(clk),
		.reset(reset),
		.spi_cs_n_i(spi_cs_n_i),
		.spi_clk_i(spi_clk_i),
		.spi_mosi_i(spi_mosi_i),
		.spi_miso_i(spi_miso_i),
		.push_o(rec_push),
		.rec_o(sniff_rec)
	);

	// absorbs bursts while the serial line catches up
	rec_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_fifo (
		.clk(clk),
		.reset(reset),
		.push_i(rec_push),
		.rec_i(sniff_rec),
		.pop_i(rec_pop),
		.empty_o(fifo_empty),
		.rec_o(head_rec),
		.dropped_o(dropped_o)
	);

	////////////////////////////////////////
	// serial output
	////////////////////////////////////////

	uart_logger #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_logger (
		.clk(clk),
		.reset(reset),
		.empty_i(fifo_empty),
		.rec_i(head_rec),
		.pop_o(rec_pop),
		.txd_o(serial_txd_o)
	);

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS = 20
) (
	output logic clk_o
);

	// free running, starts low
	initial
		clk_o = 1'b0;

	// half period per toggle
	always
		#(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== tb_spi_log.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_spi_log;
	import spi_pkg::*;
	import uart_pkg::*;

	localparam int HEADER_BYTES = 3;
	localparam int FIFO_DEPTH = 8;
	localparam int CLKS_PER_BIT = 8;
	localparam int CLK_NS = 20;
	// spi clock half period in clk cycles
	localparam int SCLK_HALF = 4;
	// random transactions in the overload test of 2 to 6 bytes each
	localparam int N_BURST = 12;
	localparam int MAX_BURST_LEN = 6;
	localparam int REC_CLKS = REC_BYTES * FRAME_BITS * CLKS_PER_BIT;
	// worst case over all tests with the directed ones first
	localparam int MAX_RECORDS = 13 + N_BURST * (HEADER_BYTES + 1);
	localparam int MAX_SPI_BYTES = 19 + N_BURST * MAX_BURST_LEN;
	localparam int N_TXN = 4 + N_BURST;
	localparam int SPI_CLKS = MAX_SPI_BYTES * 16 * SCLK_HALF + N_TXN * 4 * SCLK_HALF;
	localparam longint WATCHDOG_NS = 2 * longint'(MAX_RECORDS * REC_CLKS + SPI_CLKS) * CLK_NS;

	logic clk;
	logic reset;
	logic spi_cs_n;
	logic spi_clk;
	logic spi_mosi;
	logic spi_miso;
	logic serial_txd;
	drop_count_t dropped;

	// bytes of the next transaction
	spi_byte_t txn_mosi[$];
	spi_byte_t txn_miso[$];
	// records the serial line should carry with the oldest first
	spi_rec_t exp_q[$];
	// records put together by the serial decoder
	spi_rec_t rx_q[$];
	logic [31:0] rng_state = 32'h3bfd_f298;
	// set in the overload test where the expected stream may have gaps
	logic lossy = 1'b0;
	int lossy_rx = 0;

	tb_clock #(
		.PERIOD_NS(CLK_NS)
	) u_clock (
		.clk_o(clk)
	);

	spi_log_top #(
		.HEADER_BYTES(HEADER_BYTES),
		.FIFO_DEPTH(FIFO_DEPTH),
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_dut (
		.clk(clk),
		.reset(reset),
		.spi_cs_n_i(spi_cs_n),
		.spi_clk_i(spi_clk),
		.spi_mosi_i(spi_mosi),
		.spi_miso_i(spi_miso),
		.serial_txd_o(serial_txd),
		.dropped_o(dropped)
	);

	////////////////////////////////////////
	// checks and reference model
	////////////////////////////////////////

	task automatic stop_run(input string what);
		$display("%s", what);
		$display("** FAIL **");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_rec(input spi_rec_t expected, input spi_rec_t actual, input string name);
		if (actual !== expected)
		begin
			$display("FAIL %0d ns %s expected idx=%h mosi=%h miso=%h got idx=%h mosi=%h miso=%h",
				$time, name, expected.idx, expected.mosi, expected.miso,
				actual.idx, actual.mosi, actual.miso);
			stop_run("record mismatch");
		end
	endtask

	task automatic check_count(input drop_count_t expected, input drop_count_t actual,
		input string name);
		if (actual !== expected)
		begin
			$display("FAIL %0d ns %s expected %0d got %0d", $time, name, expected, actual);
			stop_run("count mismatch");
		end
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	// random mosi and miso bytes for one transaction
	function automatic void fill_txn(input int n_bytes);
		txn_mosi.delete();
		txn_miso.delete();
		repeat (n_bytes)
		begin
			txn_mosi.push_back(spi_byte_t'(next_rand()));
			txn_miso.push_back(spi_byte_t'(next_rand()));
		end
	endfunction

	// numbering starts at 0 with the command and only positions up to HEADER_BYTES are logged
	function automatic int expected_records();
		spi_rec_t r;
		int n;
		n = 0;
		for (int i = 0; i < txn_mosi.size(); i++)
		begin
			if (i <= HEADER_BYTES)
			begin
				r.idx = byte_idx_t'(i);
				r.mosi = txn_mosi[i];
				r.miso = txn_miso[i];
				exp_q.push_back(r);
				n++;
			end
		end
		return n;
	endfunction

	////////////////////////////////////////
	// spi bus stimulus
	////////////////////////////////////////

	// one byte in mode 0 with the msb first
	task automatic drive_byte(input spi_byte_t mosi_b, input spi_byte_t miso_b, input int n_bits);
		spi_byte_t m;
		spi_byte_t s;
		m = mosi_b;
		s = miso_b;
		repeat (n_bits)
		begin
			// data changes with the falling spi clock
			spi_clk <= 1'b0;
			spi_mosi <= m[7];
			spi_miso <= s[7];
			m = m << 1;
			s = s << 1;
			repeat (SCLK_HALF) @(posedge clk);
			spi_clk <= 1'b1;
			repeat (SCLK_HALF) @(posedge clk);
		end
	endtask

	// whole transaction that may end cut short inside one more byte
	task automatic send_transaction(input int partial_bits, output int n_exp);
		spi_byte_t junk;
		junk = spi_byte_t'(next_rand());
		n_exp = expected_records();
		@(posedge clk);
		spi_cs_n <= 1'b0;
		repeat (SCLK_HALF) @(posedge clk);
		for (int i = 0; i < txn_mosi.size(); i++)
			drive_byte(txn_mosi[i], txn_miso[i], 8);
		if (partial_bits > 0)
			drive_byte(junk, ~junk, partial_bits);
		spi_clk <= 1'b0;
		repeat (SCLK_HALF) @(posedge clk);
		spi_cs_n <= 1'b1;
		repeat (SCLK_HALF) @(posedge clk);
	endtask

	// line high for a whole record time means the logger is done
	task automatic wait_line_idle();
		int quiet;
		quiet = 0;
		while (quiet < REC_CLKS)
		begin
			@(negedge clk);
			if (serial_txd === IDLE_LEVEL)
				quiet++;
			else
				quiet = 0;
		end
	endtask

	task automatic expect_drained();
		if (exp_q.size() != 0)
			stop_run($sformatf("%0d expected records never arrived", exp_q.size()));
	endtask

	////////////////////////////////////////
	// serial decoder and compare
	////////////////////////////////////////

	// 8N1 frames sampled mid-bit on the falling clk edge
	initial
	begin : serial_decoder
		uart_byte_t rx_byte;
		logic [31:0] rx_word;
		int n_bytes;
		n_bytes = 0;
		rx_word = '0;
		rx_byte = '0;
		forever
		begin
			@(negedge clk);
			if (!reset && serial_txd === START_BIT)
			begin
				repeat (CLKS_PER_BIT / 2) @(negedge clk);
				if (serial_txd !== START_BIT)
					stop_run("start bit on the serial line was too short");
				repeat (DATA_BITS)
				begin
					repeat (CLKS_PER_BIT) @(negedge clk);
					// lsb arrives first
					rx_byte = {serial_txd, rx_byte[7:1]};
				end
				repeat (CLKS_PER_BIT) @(negedge clk);
				if (serial_txd !== STOP_BIT)
					stop_run("missing stop bit on the serial line");
				// first byte on the line is the top of the record
				rx_word = {rx_word[23:0], rx_byte};
				n_bytes++;
				if (n_bytes == REC_BYTES)
				begin
					rx_q.push_back(spi_rec_t'(rx_word));
					n_bytes = 0;
				end
			end
		end
	end

	always @(posedge clk)
	begin : compare_records
		spi_rec_t got;
		if (rx_q.size() != 0)
		begin
			got = rx_q.pop_front();
			if (exp_q.size() == 0)
				stop_run("a record arrived that no transaction produced");
			// the first FIFO_DEPTH + 1 of a burst can never be dropped
			if (!lossy || lossy_rx < FIFO_DEPTH + 1)
				check_rec(exp_q.pop_front(), got, "serial_txd_o record");
			else
			begin
				// skip records lost to the full fifo
				while (exp_q.size() > 1 && exp_q[0] != got)
					void'(exp_q.pop_front());
				check_rec(exp_q.pop_front(), got, "serial_txd_o record");
			end
			if (lossy)
				lossy_rx++;
		end
	end

	initial
	begin : watchdog
		#(WATCHDOG_NS);
		stop_run($sformatf("the run timed out after %0d ns", WATCHDOG_NS));
	end

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial
	begin : stimulus
		int n;
		int burst_total;
		spi_cs_n <= 1'b1;
		spi_clk <= 1'b0;
		spi_mosi <= 1'b0;
		spi_miso <= 1'b0;
		reset <= 1'b1;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		// idle bus keeps the line high
		repeat (REC_CLKS)
		begin
			@(negedge clk);
			if (serial_txd !== IDLE_LEVEL)
				stop_run("serial line left idle while chip select was high");
		end
		check_count('0, dropped, "dropped_o");

		// command plus header bytes
		fill_txn(1 + HEADER_BYTES);
		send_transaction(0, n);
		wait_line_idle();
		expect_drained();

		// long transaction whose tail bytes are filtered out
		fill_txn(9);
		send_transaction(0, n);
		wait_line_idle();
		expect_drained();

		// chip select rises mid byte before a fresh transaction
		fill_txn(2);
		send_transaction(5, n);
		fill_txn(3);
		send_transaction(0, n);
		wait_line_idle();
		expect_drained();
		check_count('0, dropped, "dropped_o");

		// bursts faster than the serial line
		lossy = 1'b1;
		burst_total = 0;
		for (int t = 0; t < N_BURST; t++)
		begin
			fill_txn(2 + int'(next_rand() % 32'(MAX_BURST_LEN - 1)));
			send_transaction(0, n);
			burst_total += n;
		end
		wait_line_idle();
		if (lossy_rx < FIFO_DEPTH + 1)
			stop_run($sformatf("only %0d records of the burst arrived", lossy_rx));
		if (dropped == '0)
			stop_run("the burst dropped no records");
		check_count(drop_count_t'(burst_total - lossy_rx), dropped, "dropped_o");

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
spi_pkg.sv
uart_pkg.sv
spi_sniffer.sv
rec_fifo.sv
uart_logger.sv
spi_log_top.sv
tb_clock.sv
tb_spi_log.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_spi_log
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0
PASS_MSG ?= ** PASS **

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
